// File: Makefile
TOP = tb_dbg_wb_bridge

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-Mdir obj_dir -f dbg_wb_bridge.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// File: dbg_wb_bridge.f
design/dbg_wb_pkg.sv
design/dbg_cmd_pkg.sv
design/dbg_syncflop.sv
design/dbg_cmd_capture.sv
design/dbg_wb_master.sv
design/dbg_rsp_return.sv
design/dbg_wb_bridge.sv
verification/wb_slave_model.sv
verification/tb_dbg_wb_bridge.sv

// File: design/dbg_cmd_capture.sv
// Debug command input stage: accepts one command, holds it and flips the request toggle
`default_nettype none

module dbg_cmd_capture (
  input  logic                                 src_clk,
  input  logic                                 RESET,
  input  logic                                 cmd_valid,
  input  dbg_cmd_pkg::dbg_op_e                 cmd_op,
  input  logic [dbg_wb_pkg::WB_ADDR_W-1:0]     cmd_addr,
  input  logic [dbg_wb_pkg::WB_DATA_W-1:0]     cmd_wdata,
  input  logic                                 rsp_ack,
  output logic                                 cmd_ready,
  output logic                                 req_toggle,
  output dbg_cmd_pkg::dbg_op_e                 op_hold,
  output logic [dbg_wb_pkg::WB_ADDR_W-1:0]     addr_hold,
  output logic [dbg_wb_pkg::WB_DATA_W-1:0]     wdata_hold
);

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  // High from accept until the response is acknowledged
  logic busy;
  logic accept;

  assign cmd_ready = ~busy;
  assign accept    = cmd_valid & ~busy;

  // One command in flight, rsp_ack closes it
  always_ff @(posedge src_clk or posedge RESET) begin
    if (RESET) begin
      busy <= 1'b0;
    end else if (rsp_ack) begin
      busy <= 1'b0;
    end else if (accept) begin
      busy <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Command hold and request toggle
  //////////////////////////////////////////////////

  // Toggle carries the request into the bus clock
  always_ff @(posedge src_clk or posedge RESET) begin
    if (RESET) begin
      req_toggle <= 1'b0;
    end else if (accept) begin
      req_toggle <= ~req_toggle;
    end
  end

  // Payload registers
  // Loaded together with the toggle flip, read in DEST_CLK after
  // the synchronizer delay so they are settled by then
  always_ff @(posedge src_clk) begin
    if (accept) begin
      op_hold    <= cmd_op;
      addr_hold  <= cmd_addr;
      wdata_hold <= cmd_wdata;
    end
  end

  // Held command must not move while the bus side may still sample it
  a_hold_stable : assert property (@(posedge src_clk) disable iff (RESET)
    busy |=> ($stable(op_hold) && $stable(addr_hold) && $stable(wdata_hold)));

endmodule

`default_nettype wire

// File: design/dbg_cmd_pkg.sv
// Debug command definitions: opcode encoding and the error region address bit
`default_nettype none

package dbg_cmd_pkg;

  //////////////////////////////////////////////////
  // Command opcode
  //////////////////////////////////////////////////

  // Single bit, maps straight onto wb_we
  typedef enum logic {
    DBG_READ  = 1'b0,
    DBG_WRITE = 1'b1
  } dbg_op_e;

  //////////////////////////////////////////////////
  // Error region
  //////////////////////////////////////////////////

  // Address bit that puts an access in the region answered with wb_err
  localparam int ERR_ADDR_BIT = 31;

endpackage

`default_nettype wire

// File: design/dbg_rsp_return.sv
// Response output stage: picks up the done toggle and presents the result until acknowledged
`default_nettype none

module dbg_rsp_return (
  input  logic                                 src_clk,
  input  logic                                 RESET,
  input  logic                                 done_toggle,
  input  logic [dbg_wb_pkg::WB_DATA_W-1:0]     rdata_hold,
  input  logic                                 err_hold,
  input  logic                                 rsp_ack,
  output logic                                 rsp_valid,
  output logic [dbg_wb_pkg::WB_DATA_W-1:0]     rsp_rdata,
  output logic                                 rsp_err
);

  logic done_pending;

  //////////////////////////////////////////////////
  // Done detect, back in the debug clock
  //////////////////////////////////////////////////

  dbg_syncflop u_done_sync (
    .DEST_CLK  (src_clk),
    .RESET     (RESET),
    .toggle_in (done_toggle),
    .clear     (done_pending),
    .pending   (done_pending)
  );

  //////////////////////////////////////////////////
  // Response hold
  //////////////////////////////////////////////////

  // Valid rises the edge after pending, falls on ack
  always_ff @(posedge src_clk or posedge RESET) begin
    if (RESET) begin
      rsp_valid <= 1'b0;
    end else if (done_pending) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ack) begin
      rsp_valid <= 1'b0;
    end
  end

  // Result from the bus side
  // Held registers settled long before the synchronized toggle arrives
  always_ff @(posedge src_clk) begin
    if (done_pending) begin
      rsp_rdata <= rdata_hold;
      rsp_err   <= err_hold;
    end
  end

  // Controller may only acknowledge a presented response
  a_ack_needs_valid : assert property (@(posedge src_clk) disable iff (RESET)
    rsp_ack |-> rsp_valid);

  // No second completion while one is still waiting for ack
  a_no_overrun : assert property (@(posedge src_clk) disable iff (RESET)
    done_pending |-> !rsp_valid);

endmodule

`default_nettype wire

// File: design/dbg_syncflop.sv
// Toggle synchronizer that turns each toggle edge into a sticky pending flag
`default_nettype none

module dbg_syncflop (
  input  logic DEST_CLK,
  input  logic RESET,
  input  logic toggle_in,
  input  logic clear,
  output logic pending
);

  logic sync1;
  logic sync2;
  logic sync_prev;
  logic sticky;
  logic edge_seen;

  // Either direction of the toggle counts as one event
  assign edge_seen = sync2 ^ sync_prev;
  // Edge visible at once, sticky flop keeps it afterwards
  assign pending   = edge_seen | sticky;

  // Two stage synchronizer plus previous value for edge detect
  always_ff @(posedge DEST_CLK or posedge RESET) begin
    if (RESET) begin
      sync1     <= 1'b0;
      sync2     <= 1'b0;
      sync_prev <= 1'b0;
    end else begin
      sync1     <= toggle_in;
      sync2     <= sync1;
      sync_prev <= sync2;
    end
  end

  // Clear has priority, an edge in the clear cycle was already seen on pending
  always_ff @(posedge DEST_CLK or posedge RESET) begin
    if (RESET) begin
      sticky <= 1'b0;
    end else if (clear) begin
      sticky <= 1'b0;
    end else if (edge_seen) begin
      sticky <= 1'b1;
    end
  end

  // Pending only goes away when the receiver consumed it
  a_pending_held : assert property (@(posedge DEST_CLK) disable iff (RESET)
    $fell(pending) |-> $past(clear));

endmodule

`default_nettype wire

// File: design/dbg_wb_bridge.sv
// Debug port to Wishbone bridge: command capture, bus master and response return
`default_nettype none

module dbg_wb_bridge (
  input  logic                                 src_clk,
  input  logic                                 DEST_CLK,
  input  logic                                 RESET,
  // Debug command
  input  logic                                 cmd_valid,
  input  dbg_cmd_pkg::dbg_op_e                 cmd_op,
  input  logic [dbg_wb_pkg::WB_ADDR_W-1:0]     cmd_addr,
  input  logic [dbg_wb_pkg::WB_DATA_W-1:0]     cmd_wdata,
  output logic                                 cmd_ready,
  // Debug response
  output logic                                 rsp_valid,
  output logic [dbg_wb_pkg::WB_DATA_W-1:0]     rsp_rdata,
  output logic                                 rsp_err,
  input  logic                                 rsp_ack,
  // Wishbone master
  output logic                                 wb_cyc,
  output logic                                 wb_stb,
  output logic                                 wb_we,
  output logic [dbg_wb_pkg::WB_ADDR_W-1:0]     wb_adr,
  output logic [dbg_wb_pkg::WB_DATA_W-1:0]     wb_wdata,
  input  logic [dbg_wb_pkg::WB_DATA_W-1:0]     wb_rdata,
  input  logic                                 wb_ack,
  input  logic                                 wb_err
);

  import dbg_wb_pkg::*;
  import dbg_cmd_pkg::*;

  //////////////////////////////////////////////////
  // Crossing signals
  //////////////////////////////////////////////////

  // src_clk to DEST_CLK
  logic                 req_toggle;
  dbg_op_e              op_hold;
  logic [WB_ADDR_W-1:0] addr_hold;
  logic [WB_DATA_W-1:0] wdata_hold;
  // DEST_CLK to src_clk
  logic                 done_toggle;
  logic [WB_DATA_W-1:0] rdata_hold;
  logic                 err_hold;

  dbg_cmd_capture u_cmd_capture (
    .src_clk    (src_clk),    .RESET      (RESET),
    .cmd_valid  (cmd_valid),  .cmd_op     (cmd_op),
    .cmd_addr   (cmd_addr),   .cmd_wdata  (cmd_wdata),
    .rsp_ack    (rsp_ack),    .cmd_ready  (cmd_ready),
    .req_toggle (req_toggle), .op_hold    (op_hold),
    .addr_hold  (addr_hold),  .wdata_hold (wdata_hold)
  );

  dbg_wb_master u_wb_master (
    .DEST_CLK    (DEST_CLK),    .RESET       (RESET),
    .req_toggle  (req_toggle),  .op_hold     (op_hold),
    .addr_hold   (addr_hold),   .wdata_hold  (wdata_hold),
    .wb_rdata    (wb_rdata),    .wb_ack      (wb_ack),
    .wb_err      (wb_err),      .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),      .wb_we       (wb_we),
    .wb_adr      (wb_adr),      .wb_wdata    (wb_wdata),
    .done_toggle (done_toggle), .rdata_hold  (rdata_hold),
    .err_hold    (err_hold)
  );

  dbg_rsp_return u_rsp_return (
    .src_clk     (src_clk),     .RESET       (RESET),
    .done_toggle (done_toggle), .rdata_hold  (rdata_hold),
    .err_hold    (err_hold),    .rsp_ack     (rsp_ack),
    .rsp_valid   (rsp_valid),   .rsp_rdata   (rsp_rdata),
    .rsp_err     (rsp_err)
  );

endmodule

`default_nettype wire

// File: design/dbg_wb_master.sv
// Bus side of the debug bridge: runs one Wishbone classic cycle per synchronized request
`default_nettype none

module dbg_wb_master (
  input  logic                                 DEST_CLK,
  input  logic                                 RESET,
  input  logic                                 req_toggle,
  input  dbg_cmd_pkg::dbg_op_e                 op_hold,
  input  logic [dbg_wb_pkg::WB_ADDR_W-1:0]     addr_hold,
  input  logic [dbg_wb_pkg::WB_DATA_W-1:0]     wdata_hold,
  input  logic [dbg_wb_pkg::WB_DATA_W-1:0]     wb_rdata,
  input  logic                                 wb_ack,
  input  logic                                 wb_err,
  output logic                                 wb_cyc,
  output logic                                 wb_stb,
  output logic                                 wb_we,
  output logic [dbg_wb_pkg::WB_ADDR_W-1:0]     wb_adr,
  output logic [dbg_wb_pkg::WB_DATA_W-1:0]     wb_wdata,
  output logic                                 done_toggle,
  output logic [dbg_wb_pkg::WB_DATA_W-1:0]     rdata_hold,
  output logic                                 err_hold
);

  import dbg_wb_pkg::*;
  import dbg_cmd_pkg::*;

  wb_state_e state;
  logic      req_pending;
  logic      req_clear;
  logic      bus_end;

  //////////////////////////////////////////////////
  // Request detect
  //////////////////////////////////////////////////

  dbg_syncflop u_req_sync (
    .DEST_CLK  (DEST_CLK),
    .RESET     (RESET),
    .toggle_in (req_toggle),
    .clear     (req_clear),
    .pending   (req_pending)
  );

  // Consume the request in the cycle it is taken
  assign req_clear = (state == IDLE) & req_pending;

  // Slave answered, either way
  assign bus_end = (state == CYCLE) & (wb_ack | wb_err);

  //////////////////////////////////////////////////
  // FSM and bus control
  //////////////////////////////////////////////////

  always_ff @(posedge DEST_CLK or posedge RESET) begin
    if (RESET) begin
      state       <= IDLE;
      wb_cyc      <= 1'b0;
      wb_stb      <= 1'b0;
      wb_we       <= 1'b0;
      done_toggle <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (req_pending) begin
            // Cycle opens on the edge after pending
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_we  <= (op_hold == DBG_WRITE);
            state  <= CYCLE;
          end
        end
        CYCLE: begin
          // Stalls just keep us here
          if (bus_end) begin
            wb_cyc      <= 1'b0;
            wb_stb      <= 1'b0;
            wb_we       <= 1'b0;
            done_toggle <= ~done_toggle;
            state       <= DONE;
          end
        end
        DONE: begin
          // Bus idle for one cycle before the next request
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////

  // Address and write data latched when the cycle opens
  always_ff @(posedge DEST_CLK) begin
    if (req_clear) begin
      wb_adr   <= addr_hold;
      wb_wdata <= wdata_hold;
    end
  end

  // Result latched with the done toggle, zero data for writes and errors
  always_ff @(posedge DEST_CLK) begin
    if (bus_end) begin
      rdata_hold <= (wb_we || wb_err) ? '0 : wb_rdata;
      err_hold   <= wb_err;
    end
  end

  // Classic cycle: address phase frozen until the slave responds
  a_addr_stable : assert property (@(posedge DEST_CLK) disable iff (RESET)
    (wb_stb && !wb_ack && !wb_err) |=> ($stable(wb_adr) && $stable(wb_we)));

endmodule

`default_nettype wire

// File: design/dbg_wb_pkg.sv
// Wishbone side definitions of the debug bridge: bus widths and master FSM states
`default_nettype none

package dbg_wb_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  // Full word access only, no byte selects
  localparam int WB_ADDR_W = 32;
  localparam int WB_DATA_W = 32;

  //////////////////////////////////////////////////
  // Master FSM
  //////////////////////////////////////////////////

  // IDLE waits for a synchronized request
  // CYCLE holds cyc/stb until ack or err
  // DONE is one idle bus cycle after the response is latched
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    CYCLE = 2'd1,
    DONE  = 2'd2
  } wb_state_e;

endpackage

`default_nettype wire

// File: verification/tb_dbg_wb_bridge.sv
// Testbench for the debug Wishbone bridge: random commands checked against a shadow memory
`default_nettype none

module tb_dbg_wb_bridge;

  import dbg_wb_pkg::*;
  import dbg_cmd_pkg::*;

  localparam int NUM_CMDS    = 300;
  // Timeouts in src_clk cycles
  localparam int ACCEPT_WAIT = 50;
  localparam int RSP_WAIT    = 200;

  logic                 src_clk;
  logic                 DEST_CLK;
  logic                 RESET;
  logic                 cmd_valid;
  dbg_op_e              cmd_op;
  logic [WB_ADDR_W-1:0] cmd_addr;
  logic [WB_DATA_W-1:0] cmd_wdata;
  logic                 cmd_ready;
  logic                 rsp_valid;
  logic [WB_DATA_W-1:0] rsp_rdata;
  logic                 rsp_err;
  logic                 rsp_ack;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [WB_ADDR_W-1:0] wb_adr;
  logic [WB_DATA_W-1:0] wb_wdata;
  logic [WB_DATA_W-1:0] wb_rdata;
  logic                 wb_ack;
  logic                 wb_err;

  // Reference memory, same sparse rule as the bus slave
  logic [WB_DATA_W-1:0] shadow [logic [WB_ADDR_W-1:0]];
  int                   cmd_count;

  // Command in flight, expected on the bus
  dbg_op_e              cur_op;
  logic [WB_ADDR_W-1:0] cur_addr;
  logic [WB_DATA_W-1:0] cur_wdata;

  dbg_wb_bridge UUT (
    .src_clk   (src_clk),   .DEST_CLK  (DEST_CLK),  .RESET     (RESET),
    .cmd_valid (cmd_valid), .cmd_op    (cmd_op),    .cmd_addr  (cmd_addr),
    .cmd_wdata (cmd_wdata), .cmd_ready (cmd_ready), .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata), .rsp_err   (rsp_err),   .rsp_ack   (rsp_ack),
    .wb_cyc    (wb_cyc),    .wb_stb    (wb_stb),    .wb_we     (wb_we),
    .wb_adr    (wb_adr),    .wb_wdata  (wb_wdata),  .wb_rdata  (wb_rdata),
    .wb_ack    (wb_ack),    .wb_err    (wb_err)
  );

  wb_slave_model u_slave (
    .DEST_CLK (DEST_CLK), .RESET    (RESET),    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),   .wb_we    (wb_we),    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata), .wb_rdata (wb_rdata), .wb_ack   (wb_ack),
    .wb_err   (wb_err)
  );

  //////////////////////////////////////////////////
  // Clocks
  //////////////////////////////////////////////////

  initial begin
    DEST_CLK = 1'b0;
    forever #10 DEST_CLK = ~DEST_CLK;
  end

  // Debug clock, unrelated period
  initial begin
    src_clk = 1'b0;
    forever #17 src_clk = ~src_clk;
  end

  //////////////////////////////////////////////////
  // Checks and reference model
  //////////////////////////////////////////////////

  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_rdata(input string name, input logic [WB_DATA_W-1:0] got,
                             input logic [WB_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h (command %0d)", name, got, exp, cmd_count);
      stop_run();
    end
  endtask

  task automatic check_addr(input string name, input logic [WB_ADDR_W-1:0] got,
                            input logic [WB_ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h (command %0d)", name, got, exp, cmd_count);
      stop_run();
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h (command %0d)", name, got, exp, cmd_count);
      stop_run();
    end
  endtask

  // Handshake and bus control bits
  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h (command %0d)", name, got, exp, cmd_count);
      stop_run();
    end
  endtask

  // Expected response, shadow memory updated for a good write
  task automatic model_access(input dbg_op_e op, input logic [WB_ADDR_W-1:0] addr,
                              input logic [WB_DATA_W-1:0] wdata,
                              output logic [WB_DATA_W-1:0] exp_rdata, output logic exp_err);
    exp_err   = addr[ERR_ADDR_BIT];
    exp_rdata = '0;
    if (!exp_err) begin
      if (op == DBG_WRITE) begin
        shadow[addr] = wdata;
      end else if (shadow.exists(addr)) begin
        exp_rdata = shadow[addr];
      end
    end
  endtask

  // Bus cycle carries the command in flight, looked at mid-cycle
  always @(negedge DEST_CLK) begin
    if (!RESET && wb_cyc) begin
      check_flag("wb_stb", wb_stb, 1'b1);
      check_addr("wb_adr", wb_adr, cur_addr);
      check_flag("wb_we", wb_we, cur_op == DBG_WRITE);
      if (cur_op == DBG_WRITE) begin
        check_rdata("wb_wdata", wb_wdata, cur_wdata);
      end
    end
  end

  //////////////////////////////////////////////////
  // One debug command, started on a src_clk edge
  //////////////////////////////////////////////////

  task automatic run_command(input dbg_op_e op, input logic [WB_ADDR_W-1:0] addr,
                             input logic [WB_DATA_W-1:0] wdata);
    logic [WB_DATA_W-1:0] exp_rdata;
    logic                 exp_err;
    int                   cnt;
    int                   ack_delay;
    model_access(op, addr, wdata, exp_rdata, exp_err);
    cur_op    = op;
    cur_addr  = addr;
    cur_wdata = wdata;
    @(posedge src_clk);
    cmd_valid <= 1'b1;
    cmd_op    <= op;
    cmd_addr  <= addr;
    cmd_wdata <= wdata;
    // cmd_ready seen mid-cycle, accepted on the next rising edge
    cnt = 0;
    @(negedge src_clk);
    while (!cmd_ready && cnt < ACCEPT_WAIT) begin
      @(negedge src_clk);
      cnt++;
    end
    if (!cmd_ready) begin
      $display("Timeout: command %0d was never accepted", cmd_count);
      stop_run();
    end
    @(posedge src_clk);
    cmd_valid <= 1'b0;
    // In flight, cmd_ready must stay low
    cnt = 0;
    @(negedge src_clk);
    while (!rsp_valid && cnt < RSP_WAIT) begin
      check_flag("cmd_ready", cmd_ready, 1'b0);
      @(negedge src_clk);
      cnt++;
    end
    if (!rsp_valid) begin
      $display("Timeout: no response for command %0d", cmd_count);
      stop_run();
    end
    check_flag("cmd_ready", cmd_ready, 1'b0);
    check_rdata("rsp_rdata", rsp_rdata, exp_rdata);
    check_err("rsp_err", rsp_err, exp_err);
    // Controller acknowledges late, response must be held
    ack_delay = int'($urandom % 5);
    repeat (ack_delay) begin
      @(negedge src_clk);
      check_flag("rsp_valid", rsp_valid, 1'b1);
      check_flag("cmd_ready", cmd_ready, 1'b0);
    end
    @(posedge src_clk);
    rsp_ack <= 1'b1;
    @(posedge src_clk);
    rsp_ack <= 1'b0;
    // Ack taken on this edge, response gone and ready again
    @(negedge src_clk);
    check_flag("rsp_valid", rsp_valid, 1'b0);
    check_flag("cmd_ready", cmd_ready, 1'b1);
    cmd_count++;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    dbg_op_e              rnd_op;
    logic [WB_ADDR_W-1:0] rnd_addr;
    logic [WB_DATA_W-1:0] rnd_data;
    void'($urandom(32'hcd8d));
    RESET     <= 1'b1;
    cmd_valid <= 1'b0;
    cmd_op    <= DBG_READ;
    cmd_addr  <= '0;
    cmd_wdata <= '0;
    rsp_ack   <= 1'b0;
    cmd_count = 0;
    repeat (10) @(posedge DEST_CLK);
    RESET <= 1'b0;
    repeat (2) @(posedge src_clk);

    // Quiet after reset
    check_flag("cmd_ready", cmd_ready, 1'b1);
    check_flag("rsp_valid", rsp_valid, 1'b0);
    check_flag("wb_cyc", wb_cyc, 1'b0);
    check_flag("wb_stb", wb_stb, 1'b0);

    // Write then read back
    run_command(DBG_WRITE, 32'h0000_0010, 32'ha5a5_1234);
    run_command(DBG_READ, 32'h0000_0010, 32'h0);
    // Never written, reads zero
    run_command(DBG_READ, 32'h0000_1000, 32'h0);
    // Error region, then the same word outside it
    run_command(DBG_WRITE, 32'h8000_0020, 32'hdead_beef);
    run_command(DBG_READ, 32'h8000_0020, 32'h0);
    run_command(DBG_READ, 32'h0000_0020, 32'h0);

    // Random mix over 16 words, about one in six in the error region
    while (cmd_count < NUM_CMDS) begin
      rnd_op   = ($urandom % 2 == 0) ? DBG_READ : DBG_WRITE;
      rnd_addr = {($urandom % 6 == 0), 25'h0, 4'($urandom % 16), 2'b00};
      rnd_data = $urandom;
      run_command(rnd_op, rnd_addr, rnd_data);
      repeat ($urandom % 3) @(posedge src_clk);
    end

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/wb_slave_model.sv
// Wishbone classic slave model: sparse word memory with random wait states and an error region
`default_nettype none

module wb_slave_model (
  input  logic                             DEST_CLK,
  input  logic                             RESET,
  input  logic                             wb_cyc,
  input  logic                             wb_stb,
  input  logic                             wb_we,
  input  logic [dbg_wb_pkg::WB_ADDR_W-1:0] wb_adr,
  input  logic [dbg_wb_pkg::WB_DATA_W-1:0] wb_wdata,
  output logic [dbg_wb_pkg::WB_DATA_W-1:0] wb_rdata,
  output logic                             wb_ack,
  output logic                             wb_err
);

  import dbg_wb_pkg::*;
  import dbg_cmd_pkg::*;

  // Longest stall in bus cycles
  localparam int MAX_WAIT = 5;

  // Sparse storage, a missing entry reads as zero
  logic [WB_DATA_W-1:0] mem [logic [WB_ADDR_W-1:0]];
  logic [2:0]           wait_cnt;

  //////////////////////////////////////////////////
  // Registered response
  //////////////////////////////////////////////////

  always @(posedge DEST_CLK or posedge RESET) begin
    if (RESET) begin
      wb_ack   <= 1'b0;
      wb_err   <= 1'b0;
      wb_rdata <= '0;
      wait_cnt <= 3'd0;
    end else if (wb_ack || wb_err) begin
      // Single cycle response, master drops stb on this edge
      wb_ack <= 1'b0;
      wb_err <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (wait_cnt != 3'd0) begin
        // Stall
        wait_cnt <= wait_cnt - 3'd1;
      end else if (wb_adr[ERR_ADDR_BIT]) begin
        // Error region, memory left alone
        wb_err   <= 1'b1;
        wb_rdata <= '0;
      end else begin
        wb_ack <= 1'b1;
        if (wb_we) begin
          mem[wb_adr] = wb_wdata;
          wb_rdata    <= '0;
        end else begin
          wb_rdata <= mem.exists(wb_adr) ? mem[wb_adr] : '0;
        end
      end
    end else begin
      // Bus idle, pick the stall length for the next cycle
      wait_cnt <= 3'($urandom % (MAX_WAIT + 1));
    end
  end

endmodule

`default_nettype wire
